//--- list.f
rtl/fb_pkg.sv
rtl/display_timing.sv
rtl/fb_bram.sv
rtl/fb_clear.sv
rtl/fb_write_arb.sv
rtl/fb_scanout.sv
rtl/fb_display_top.sv
tests/tb_fb_display.sv

//--- Bender.yml
package:
  name: fb_display

sources:
  - files:
      - rtl/fb_pkg.sv
      - rtl/display_timing.sv
      - rtl/fb_bram.sv
      - rtl/fb_clear.sv
      - rtl/fb_write_arb.sv
      - rtl/fb_scanout.sv
      - rtl/fb_display_top.sv
  - target: test
    files:
      - tests/tb_fb_display.sv

//--- tests/tb_fb_display.sv
// testbench for the mono framebuffer display
// pixel model, reference colour function, raster and colour checker

`timescale 1ns/1ps

module tb_fb_display;

    localparam int max_cycles = 5 * 800 * 525;  // four frames to finish, one spare

    logic clk_pix;
    logic rst_n;
    logic wr_en;
    logic [7:0] wr_x;
    logic [6:0] wr_y;
    logic wr_bit;
    logic clear_start;
    logic clear_bit;
    logic clear_busy;
    logic hsync;
    logic vsync;
    logic de;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    logic   model [0:19199];          // expected framebuffer bits
    integer seed = 32'he03c2013;
    string  test_name = "reset";
    int     errors = 0;
    int     cycles = 0;
    int     frames_done = 0;          // checked frames whose active area has ended
    int     cur_x = 0;
    int     cur_y = 0;

    fb_display_top dut (
        .clk_pix     (clk_pix),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_x        (wr_x),
        .wr_y        (wr_y),
        .wr_bit      (wr_bit),
        .clear_start (clear_start),
        .clear_bit   (clear_bit),
        .clear_busy  (clear_busy),
        .hsync       (hsync),
        .vsync       (vsync),
        .de          (de),
        .r           (r),
        .g           (g),
        .b           (b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // 4 ns period
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("error: test %s, %s expected %0h actual %0h (x=%0d y=%0d)",
                     test_name, name, exp, act, cur_x, cur_y);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // colour seen on screen: black in blanking, bg outside the 160x120 area
    function automatic logic [11:0] ref_pixel(input logic de_v, input int x, input int y);
        if (!de_v) begin
            return 12'h000;
        end else if (x >= 160 || y >= 120) begin
            return 12'h137;
        end else begin
            return model[y * 160 + x] ? 12'hFFF : 12'h000;
        end
    endfunction

    task automatic host_write(input int x, input int y, input logic bit_v);
        wr_en  = 1'b1;
        wr_x   = x[7:0];
        wr_y   = y[6:0];
        wr_bit = bit_v;
        if (x < 160 && y < 120) begin
            model[y * 160 + x] = bit_v;  // out of range is dropped
        end
        @(posedge clk_pix);
        #1;
        wr_en = 1'b0;
    endtask

    // one clear, host strobes every 100 cycles, restart try at cycle 1000
    task automatic run_clear(input logic fill, input int n_host, output int busy_len);
        int k;
        int swept;
        int hx;
        int hy;
        k        = 0;
        swept    = 0;
        busy_len = 0;
        clear_start = 1'b1;
        clear_bit   = fill;
        @(posedge clk_pix);
        #1;
        clear_start = 1'b0;
        clear_bit   = !fill;  // opposite value for the restart try
        while (clear_busy) begin
            busy_len++;
            wr_en       = (k % 100 == 7) && (k / 100 < n_host);
            clear_start = (k == 1000);  // must not restart or relatch
            if (wr_en) begin
                hx = $unsigned($random(seed)) % 160;
                hy = 60 + $unsigned($random(seed)) % 60;  // rows still ahead of the sweep
                wr_x   = hx[7:0];
                wr_y   = hy[6:0];
                wr_bit = 1'b1;
                model[hy * 160 + hx] = 1'b1;
            end else if (swept < 19200) begin
                model[swept] = fill;  // clear owns the port this cycle
                swept++;
            end
            k++;
            @(posedge clk_pix);
            #1;
        end
        wr_en       = 1'b0;
        clear_start = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        while (frames_done < n) begin
            @(posedge clk_pix);
        end
        #1;
    endtask

    // raster and colour checker, outputs sampled mid-cycle
    logic prev_de = 1'b0;
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;
    logic tracking = 1'b0;   // set from the first frame after a vsync
    logic vs_seen = 1'b0;
    logic after_de = 1'b0;
    int   de_len = 0;
    int   line_cnt = 0;
    int   gap = 0;
    int   hs_len = 0;
    int   vs_len = 0;

    always @(negedge clk_pix) begin
        if (rst_n) begin
            if (!vsync) vs_seen = 1'b1;
            if (de && !prev_de) begin
                if (vs_seen) begin  // first de after vsync starts a frame
                    tracking = 1'b1;
                    vs_seen  = 1'b0;
                    cur_y    = 0;
                    line_cnt = 0;
                end else begin
                    cur_y++;
                end
                cur_x  = 0;
                de_len = 0;
            end
            if (de) de_len++;
            if (!de && prev_de) begin
                check_val("de_per_line", 640, de_len);
                gap      = 0;
                after_de = 1'b1;
                line_cnt++;
                if (tracking && line_cnt == 480) frames_done++;
            end else if (after_de) begin
                gap++;
            end
            if (!hsync && prev_hs) begin
                if (after_de) check_val("hsync_delay", 16, gap);
                after_de = 1'b0;
                hs_len   = 0;
            end
            if (!hsync) hs_len++;
            if (hsync && !prev_hs) check_val("hsync_width", 96, hs_len);
            if (!vsync && prev_vs) begin
                if (tracking) check_val("active_lines", 480, line_cnt);
                vs_len = 0;
            end
            if (!vsync) vs_len++;
            if (vsync && !prev_vs) check_val("vsync_width", 2 * 800, vs_len);
            if (tracking || !de) begin
                check_val("pixel", ref_pixel(de, cur_x, cur_y), {r, g, b});
            end
            if (de) cur_x++;
            prev_de = de;
            prev_hs = hsync;
            prev_vs = vsync;
        end
    end

    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d clock cycles", cycles);
            $display("STATUS: FAIL");
            $fatal(1, "stopped by timeout");
        end
    end

    initial begin
        int len;
        int x;
        int y;
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_x        = '0;
        wr_y        = '0;
        wr_bit      = 1'b0;
        clear_start = 1'b0;
        clear_bit   = 1'b0;
        for (int i = 0; i < 19200; i++) model[i] = 1'b0;  // memory starts black
        repeat (4) @(posedge clk_pix);
        check_val("reset_outputs", 32'h0000_C000, {hsync, vsync, de, r, g, b, clear_busy});
        #1;
        rst_n = 1'b1;
        @(posedge clk_pix);
        #1;

        // fill with ones, no host traffic, frame 1 all fg
        test_name = "clear_fill";
        run_clear(1'b1, 0, len);
        check_val("clear_busy_len", 19200, len);
        wait_frames(1);

        // edges first, then random writes mixed with dropped ones
        test_name = "host_writes";
        host_write(0, 0, 1'b0);
        host_write(159, 0, 1'b0);
        host_write(0, 119, 1'b0);
        host_write(159, 119, 1'b0);
        host_write(0, 50, 1'b0);
        host_write(159, 50, 1'b0);
        for (int i = 0; i < 300; i++) begin
            x = $unsigned($random(seed)) % 160;
            y = $unsigned($random(seed)) % 120;
            host_write(x, y, $random(seed));
            if (i % 8 == 3) begin
                x = 160 + $unsigned($random(seed)) % 96;   // x past the edge
                host_write(x, $unsigned($random(seed)) % 128, 1'b1);
            end else if (i % 8 == 6) begin
                y = 120 + $unsigned($random(seed)) % 8;    // y past the edge
                host_write($unsigned($random(seed)) % 160, y, 1'b1);
            end
        end
        wait_frames(2);

        // clear to zero while host writes steal 50 cycles
        test_name = "clear_arbitration";
        run_clear(1'b0, 50, len);
        check_val("clear_busy_len", 19250, len);
        wait_frames(3);

        if (errors == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- rtl/fb_display_top.sv
// top level of the mono framebuffer display
// timing, memory, write arbiter, clear engine and scanout

`timescale 1ns/1ps

module fb_display_top (
    input  logic          clk_pix,
    input  logic          rst_n,
    input  logic          wr_en,        // host pixel strobe
    input  fb_pkg::fb_x_t wr_x,
    input  fb_pkg::fb_y_t wr_y,
    input  logic          wr_bit,
    input  logic          clear_start,
    input  logic          clear_bit,
    output logic          clear_busy,
    output logic          hsync,
    output logic          vsync,
    output logic          de,
    output fb_pkg::chan_t r,
    output fb_pkg::chan_t g,
    output fb_pkg::chan_t b
);

    // raster
    fb_pkg::coord_t sx;
    fb_pkg::coord_t sy;
    logic t_hsync;
    logic t_vsync;
    logic t_de;
    logic t_frame;

    // memory ports
    fb_pkg::fb_addr_t rd_addr;
    logic             rd_data;
    logic             we;
    fb_pkg::fb_addr_t wr_addr;
    logic             wr_data;

    // clear engine to arbiter
    logic             clr_req;
    logic             clr_grant;
    fb_pkg::fb_addr_t clr_addr;
    logic             clr_bit;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (t_hsync),
        .vsync   (t_vsync),
        .de      (t_de),
        .frame   (t_frame)
    );

    fb_bram u_bram (
        .clk_pix (clk_pix),
        .we      (we),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fb_clear u_clear (
        .clk_pix     (clk_pix),
        .rst_n       (rst_n),
        .clear_start (clear_start),
        .clear_bit   (clear_bit),
        .clr_grant   (clr_grant),
        .clr_req     (clr_req),
        .clr_addr    (clr_addr),
        .clr_bit     (clr_bit),
        .clear_busy  (clear_busy)
    );

    fb_write_arb u_arb (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_x      (wr_x),
        .wr_y      (wr_y),
        .wr_bit    (wr_bit),
        .clr_req   (clr_req),
        .clr_addr  (clr_addr),
        .clr_bit   (clr_bit),
        .clr_grant (clr_grant),
        .we        (we),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    fb_scanout u_scanout (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .sx       (sx),
        .sy       (sy),
        .hsync_in (t_hsync),
        .vsync_in (t_vsync),
        .de_in    (t_de),
        .frame    (t_frame),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .r        (r),
        .g        (g),
        .b        (b)
    );

endmodule

//--- rtl/fb_scanout.sv
// scanout: framebuffer read address ahead of the beam
// colour select, blanking, registered display outputs

`timescale 1ns/1ps

module fb_scanout (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  fb_pkg::coord_t   sx,
    input  fb_pkg::coord_t   sy,
    input  logic             hsync_in,
    input  logic             vsync_in,
    input  logic             de_in,
    input  logic             frame,
    output fb_pkg::fb_addr_t rd_addr,
    input  logic             rd_data,   // bit for the pixel at sx,sy
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output fb_pkg::chan_t    r,
    output fb_pkg::chan_t    g,
    output fb_pkg::chan_t    b
);

    logic lead_same;   // lead position still on this line
    logic lead_next;   // lead has wrapped onto the next line
    logic paint_area;
    logic [3*fb_pkg::chanw-1:0] colr;

    // beam position plus read_lat, wrapped, inside the framebuffer
    always_comb begin
        lead_same = (sy < fb_pkg::fb_height) &&
                    (sx < fb_pkg::fb_width - fb_pkg::read_lat);
        lead_next = (sx >= fb_pkg::h_total - fb_pkg::read_lat) &&
                    (sy == fb_pkg::v_total - 1 || sy < fb_pkg::fb_height - 1);
    end

    // rd_addr holds the address of the pixel one ahead of the beam
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= fb_pkg::fb_addr_t'(fb_pkg::read_lat - 1);  // beam sits at 0,0
        end else if (frame) begin
            // resync, lead is read_lat into the buffer at 0,0
            rd_addr <= fb_pkg::fb_addr_t'(fb_pkg::read_lat);
        end else if (lead_same || lead_next) begin
            if (rd_addr == fb_pkg::fb_addr_t'(fb_pkg::fb_pixels - 1)) begin
                rd_addr <= '0;  // last pixel, wrap for next frame
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // pick colour for this pixel
    always_comb begin
        paint_area = (sx < fb_pkg::fb_width) && (sy < fb_pkg::fb_height);
        if (!de_in) begin
            colr = '0;  // blanking is black
        end else if (paint_area) begin
            colr = rd_data ? fb_pkg::colr_fg : fb_pkg::colr_off;
        end else begin
            colr = fb_pkg::colr_bg;
        end
    end

    // output stage, syncs and colour move together
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;  // inactive
            vsync <= 1'b1;
            de    <= 1'b0;
            r     <= '0;
            g     <= '0;
            b     <= '0;
        end else begin
            hsync <= hsync_in;
            vsync <= vsync_in;
            de    <= de_in;
            {r, g, b} <= colr;
        end
    end

endmodule

//--- rtl/fb_write_arb.sv
// write-port arbiter, host over clear engine
// range check and x,y to linear address for host writes

`timescale 1ns/1ps

module fb_write_arb (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  logic             wr_en,      // host strobe
    input  fb_pkg::fb_x_t    wr_x,
    input  fb_pkg::fb_y_t    wr_y,
    input  logic             wr_bit,
    input  logic             clr_req,
    input  fb_pkg::fb_addr_t clr_addr,
    input  logic             clr_bit,
    output logic             clr_grant,
    output logic             we,
    output fb_pkg::fb_addr_t wr_addr,
    output logic             wr_data
);

    logic             live;       // port open once out of reset
    logic             in_range;
    logic             host_ok;
    fb_pkg::fb_addr_t host_addr;

    // keeps stray host strobes away from the memory until reset has gone
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    always_comb begin
        in_range  = (wr_x < fb_pkg::fb_width) && (wr_y < fb_pkg::fb_height);
        host_ok   = live && wr_en && in_range;  // out of range just dropped
        // y*160 + x, fits 15 bits
        host_addr = fb_pkg::fb_addr_t'(wr_y) * fb_pkg::fb_addr_t'(fb_pkg::fb_width)
                  + fb_pkg::fb_addr_t'(wr_x);
    end

    // fixed priority, clear waits a cycle per host write
    always_comb begin
        clr_grant = live && clr_req && !host_ok;
        we        = host_ok || clr_grant;
        wr_addr   = host_ok ? host_addr : clr_addr;
        wr_data   = host_ok ? wr_bit : clr_bit;
    end

endmodule

//--- rtl/fb_clear.sv
// clear engine
// walks every framebuffer address once, writing a latched fill bit

`timescale 1ns/1ps

module fb_clear (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  logic             clear_start,  // pulse
    input  logic             clear_bit,    // sampled with clear_start
    input  logic             clr_grant,    // write port is ours this cycle
    output logic             clr_req,
    output fb_pkg::fb_addr_t clr_addr,
    output logic             clr_bit,
    output logic             clear_busy
);

    fb_pkg::clear_state_t state;
    logic fill;  // value being written
    logic last_addr;

    always_comb last_addr = (clr_addr == fb_pkg::fb_addr_t'(fb_pkg::fb_pixels - 1));

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state    <= fb_pkg::clr_idle;
            clr_addr <= '0;
        end else begin
            case (state)
                fb_pkg::clr_idle: begin
                    if (clear_start) begin
                        state    <= fb_pkg::clr_run;
                        clr_addr <= '0;
                    end
                end
                fb_pkg::clr_run: begin
                    // hold address while host owns the port
                    if (clr_grant) begin
                        if (last_addr) begin
                            state <= fb_pkg::clr_idle;
                        end else begin
                            clr_addr <= clr_addr + 1'b1;
                        end
                    end
                end
                default: state <= fb_pkg::clr_idle;
            endcase
        end
    end

    // fill value only taken when starting from idle
    always_ff @(posedge clk_pix) begin
        if (clear_start && state == fb_pkg::clr_idle) begin
            fill <= clear_bit;
        end
    end

    always_comb begin
        clr_req    = (state == fb_pkg::clr_run);
        clear_busy = (state == fb_pkg::clr_run);  // restart ignored while high
        clr_bit    = fill;
    end

endmodule

//--- rtl/fb_bram.sv
// framebuffer memory, 19200 x 1 bit
// one write port, one registered read port, same clock

`timescale 1ns/1ps

module fb_bram (
    input  logic             clk_pix,
    input  logic             we,
    input  fb_pkg::fb_addr_t wr_addr,
    input  logic             wr_data,
    input  fb_pkg::fb_addr_t rd_addr,
    output logic             rd_data   // valid one cycle after rd_addr
);

    // starts all black
    logic mem [fb_pkg::fb_pixels] = '{default: 1'b0};

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[wr_addr] <= wr_data;  // seen by reads next cycle
        end
    end

    // read is registered for block RAM inference
    always_ff @(posedge clk_pix) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/display_timing.sv
// raster generator for 640x480
// free-running x/y counters, sync decode, data enable, frame pulse

`timescale 1ns/1ps

module display_timing (
    input  logic           clk_pix,
    input  logic           rst_n,
    output fb_pkg::coord_t sx,      // 0..799
    output fb_pkg::coord_t sy,      // 0..524
    output logic           hsync,   // active low
    output logic           vsync,   // active low
    output logic           de,      // active area
    output logic           frame    // one cycle at 0,0
);

    logic last_x;
    logic last_y;

    always_comb begin
        last_x = (sx == fb_pkg::h_total - 1);
        last_y = (sy == fb_pkg::v_total - 1);
    end

    // counters, line wrap then frame wrap
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (last_x) begin
            sx <= '0;
            if (last_y) begin
                sy <= '0;
            end else begin
                sy <= fb_pkg::coord_t'(sy + 1);
            end
        end else begin
            sx <= fb_pkg::coord_t'(sx + 1);
        end
    end

    // sync pulses sit after the front porch
    always_comb begin
        hsync = ~(sx >= fb_pkg::h_active + fb_pkg::h_front &&
                  sx <  fb_pkg::h_active + fb_pkg::h_front + fb_pkg::h_sync);
        vsync = ~(sy >= fb_pkg::v_active + fb_pkg::v_front &&
                  sy <  fb_pkg::v_active + fb_pkg::v_front + fb_pkg::v_sync);
    end

    always_comb begin
        de    = (sx < fb_pkg::h_active) && (sy < fb_pkg::v_active);
        frame = (sx == 0) && (sy == 0);  // first active pixel
    end

endmodule

//--- rtl/fb_pkg.sv
// shared constants and types for the mono framebuffer display
// raster timing, framebuffer geometry, colours, clear FSM states

package fb_pkg;

    // screen coordinates, signed
    localparam int cordw = 16;
    typedef logic signed [cordw-1:0] coord_t;

    // 640x480 horizontal timing in pixels
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;   // active low
    localparam int h_back   = 48;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 800

    // vertical timing in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;    // active low
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 525

    // framebuffer geometry, one bit per pixel
    localparam int fb_width  = 160;
    localparam int fb_height = 120;
    localparam int fb_pixels = fb_width * fb_height;  // 19200
    localparam int fb_addrw  = 15;
    typedef logic [fb_addrw-1:0] fb_addr_t;
    typedef logic [7:0] fb_x_t;  // host x, 0..159 valid
    typedef logic [6:0] fb_y_t;  // host y, 0..119 valid

    // colour, 4 bits per channel, red in top nibble
    localparam int chanw = 4;
    typedef logic [chanw-1:0] chan_t;
    localparam logic [3*chanw-1:0] colr_fg  = 12'hFFF;  // bit set
    localparam logic [3*chanw-1:0] colr_off = 12'h000;  // bit clear
    localparam logic [3*chanw-1:0] colr_bg  = 12'h137;  // outside framebuffer

    // read lead: address register + memory
    localparam int read_lat = 2;

    typedef enum logic {
        clr_idle,
        clr_run
    } clear_state_t;

endpackage
